// File: sim.f
rtl/exec_pkg.sv
rtl/reservation_station.sv
rtl/int_alu.sv
rtl/exec_cluster.sv
tb/exec_cluster_properties.sv
tb/exec_cluster_tb.sv

// File: Makefile
TOP = exec_cluster_tb

all: run

run:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Everything OK"

lint:
	verilator --lint-only --timing -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all run lint clean

// File: tb/exec_cluster_tb.sv
`timescale 1ns/1ps

module exec_cluster_tb;

    localparam int max_cycles = 2000;

    logic               clk = 1'b0;
    logic               rst;
    logic               ena;
    logic               dispatch;
    logic               has_capacity;
    exec_pkg::alu_op_t  op;
    exec_pkg::data_t    vj, vk, pc, imm, ls_cdb_data, alu_cdb_data;
    exec_pkg::rob_tag_t qj, qk, rd_tag, ls_cdb_tag, alu_cdb_tag;
    integer             seed;
    int                 errors = 0;
    int                 cycles = 0;

    exec_cluster dut0 (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout after %0d cycles, the tests did not finish", cycles);
            $display("Something failed");
            $finish;
        end
    end

    // expected ALU result
    function automatic exec_pkg::data_t model_result(exec_pkg::alu_op_t m_op,
            exec_pkg::data_t a, exec_pkg::data_t b, exec_pkg::data_t m_pc,
            exec_pkg::data_t m_imm);
        case (m_op)
            exec_pkg::add:    return a + b;
            exec_pkg::sub:    return a - b;
            exec_pkg::op_and: return a & b;
            exec_pkg::op_or:  return a | b;
            exec_pkg::op_xor: return a ^ b;
            exec_pkg::sll:    return a << b[4:0];
            exec_pkg::srl:    return a >> b[4:0];
            exec_pkg::slt:    return {31'b0, $signed(a) < $signed(b)};
            exec_pkg::addi:   return a + m_imm;
            exec_pkg::auipc:  return m_pc + m_imm;
            default:          return '0;
        endcase
    endfunction

    task automatic check_tag(input string name, input exec_pkg::rob_tag_t exp,
            input exec_pkg::rob_tag_t got);
        if (got !== exp) begin
            $display("ERROR %0t %s: expected %0d, got %0d", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic check_data(input string name, input exec_pkg::data_t exp,
            input exec_pkg::data_t got);
        if (got !== exp) begin
            $display("ERROR %0t %s: expected %h, got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("ERROR %0t %s: expected %b, got %b", $time, name, exp, got);
            errors++;
        end
    endtask

    // one-cycle dispatch strobe, starts and ends just after a falling edge
    task automatic send_op(input exec_pkg::alu_op_t s_op, input exec_pkg::data_t s_vj,
            input exec_pkg::data_t s_vk, input exec_pkg::rob_tag_t s_qj,
            input exec_pkg::rob_tag_t s_qk, input exec_pkg::data_t s_pc,
            input exec_pkg::data_t s_imm, input exec_pkg::rob_tag_t s_tag);
        op       = s_op;
        vj       = s_vj;
        vk       = s_vk;
        qj       = s_qj;
        qk       = s_qk;
        pc       = s_pc;
        imm      = s_imm;
        rd_tag   = s_tag;
        dispatch = 1'b1;
        @(negedge clk);
        dispatch = 1'b0;
    endtask

    // result must show up exactly two cycles after the dispatch edge
    task automatic expect_in_two(input exec_pkg::rob_tag_t tag, input exec_pkg::data_t exp);
        @(negedge clk);
        check_tag("alu_cdb_tag", exec_pkg::no_tag, alu_cdb_tag);
        @(negedge clk);
        check_tag("alu_cdb_tag", tag, alu_cdb_tag);
        check_data("alu_cdb_data", exp, alu_cdb_data);
    endtask

    task automatic wait_for_tag(input exec_pkg::rob_tag_t tag, output exec_pkg::data_t got,
            output int waited);
        bit found;
        found  = 1'b0;
        waited = 0;
        got    = '0;
        while (!found && waited < 40) begin
            @(negedge clk);
            waited++;
            if (alu_cdb_tag == tag) begin
                found = 1'b1;
                got   = alu_cdb_data;
            end
        end
        if (!found) begin
            $display("tag %0d was never broadcast on the ALU bus", tag);
            errors++;
        end
    endtask

    task automatic test_each_op();
        exec_pkg::alu_op_t t_op;
        exec_pkg::data_t   a, b, p, i;
        for (int n = 1; n <= 10; n++) begin
            t_op = exec_pkg::alu_op_t'(n);
            a    = $random(seed);
            b    = $random(seed);
            p    = $random(seed);
            i    = $random(seed);
            send_op(t_op, a, b, exec_pkg::no_tag, exec_pkg::no_tag, p, i,
                    exec_pkg::rob_tag_t'(n));
            expect_in_two(exec_pkg::rob_tag_t'(n), model_result(t_op, a, b, p, i));
        end
    endtask

    task automatic test_load_wait();
        exec_pkg::data_t ld, b, got;
        int              waited;
        ld = $random(seed);
        b  = $random(seed);
        send_op(exec_pkg::add, '0, b, 4'd5, exec_pkg::no_tag, '0, '0, 4'd6);
        repeat (4) begin
            @(negedge clk);
            check_tag("alu_cdb_tag", exec_pkg::no_tag, alu_cdb_tag);
        end
        ls_cdb_tag  = 4'd5;
        ls_cdb_data = ld;
        @(negedge clk);
        ls_cdb_tag = exec_pkg::no_tag;
        wait_for_tag(4'd6, got, waited);
        check_data("alu_cdb_data", model_result(exec_pkg::add, ld, b, '0, '0), got);
        if (waited < 2) begin
            $display("load-wait result came %0d cycle after the load broadcast", waited);
            errors++;
        end
    endtask

    task automatic test_chain();
        exec_pkg::data_t a, b, c, r1, got;
        int              waited;
        a  = $random(seed);
        b  = $random(seed);
        c  = $random(seed);
        r1 = model_result(exec_pkg::op_xor, a, b, '0, '0);
        send_op(exec_pkg::op_xor, a, b, exec_pkg::no_tag, exec_pkg::no_tag, '0, '0, 4'd1);
        send_op(exec_pkg::sub, '0, c, 4'd1, exec_pkg::no_tag, '0, '0, 4'd2);
        wait_for_tag(4'd1, got, waited);
        check_data("alu_cdb_data", r1, got);
        wait_for_tag(4'd2, got, waited);
        check_data("alu_cdb_data", model_result(exec_pkg::sub, r1, c, '0, '0), got);
    endtask

    task automatic test_bypass();
        exec_pkg::data_t ld, b;
        ld          = $random(seed);
        b           = $random(seed);
        ls_cdb_tag  = 4'd7;
        ls_cdb_data = ld;
        send_op(exec_pkg::op_or, '0, b, 4'd7, exec_pkg::no_tag, '0, '0, 4'd8);
        ls_cdb_tag = exec_pkg::no_tag;
        expect_in_two(4'd8, model_result(exec_pkg::op_or, ld, b, '0, '0));
    endtask

    task automatic test_capacity();
        exec_pkg::data_t   ld;
        exec_pkg::data_t   b_val [15];
        exec_pkg::alu_op_t ops [15];
        int                k;
        ld = $random(seed);
        for (int n = 0; n < 15; n++) begin
            check_bit("has_capacity", 1'b1, has_capacity);
            ops[n]   = exec_pkg::alu_op_t'(1 + n % 10);
            b_val[n] = $random(seed);
            send_op(ops[n], '0, b_val[n], 4'd15, exec_pkg::no_tag, 32'h400, 32'h24,
                    exec_pkg::rob_tag_t'(n + 1));
        end
        check_bit("has_capacity", 1'b0, has_capacity);
        ls_cdb_tag  = 4'd15;
        ls_cdb_data = ld;
        @(negedge clk);
        ls_cdb_tag = exec_pkg::no_tag;
        k = 0;
        // results must come out in entry order, one each
        repeat (20) begin
            @(negedge clk);
            if (alu_cdb_tag != exec_pkg::no_tag) begin
                if (k < 15) begin
                    check_tag("alu_cdb_tag", exec_pkg::rob_tag_t'(k + 1), alu_cdb_tag);
                    check_data("alu_cdb_data",
                               model_result(ops[k], ld, b_val[k], 32'h400, 32'h24),
                               alu_cdb_data);
                end
                k++;
            end
        end
        if (k != 15) begin
            $display("capacity test saw %0d results instead of 15", k);
            errors++;
        end
        check_bit("has_capacity", 1'b1, has_capacity);
    endtask

    task automatic test_stall();
        exec_pkg::data_t a, b, got;
        int              waited;
        a = $random(seed);
        b = $random(seed);
        send_op(exec_pkg::sll, a, b, exec_pkg::no_tag, exec_pkg::no_tag, '0, '0, 4'd3);
        // op sits in the issue register when the stall starts
        @(negedge clk);
        ena = 1'b0;
        repeat (5) begin
            @(negedge clk);
            check_tag("alu_cdb_tag", exec_pkg::no_tag, alu_cdb_tag);
        end
        ena = 1'b1;
        wait_for_tag(4'd3, got, waited);
        check_data("alu_cdb_data", model_result(exec_pkg::sll, a, b, '0, '0), got);
    endtask

    initial begin
        seed        = 32'h7d5ede3d;
        rst         = 1'b1;
        ena         = 1'b1;
        dispatch    = 1'b0;
        op          = exec_pkg::nop;
        vj          = '0;
        vk          = '0;
        pc          = '0;
        imm         = '0;
        qj          = exec_pkg::no_tag;
        qk          = exec_pkg::no_tag;
        rd_tag      = exec_pkg::no_tag;
        ls_cdb_tag  = exec_pkg::no_tag;
        ls_cdb_data = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_bit("has_capacity", 1'b1, has_capacity);
        check_tag("alu_cdb_tag", exec_pkg::no_tag, alu_cdb_tag);
        test_each_op();
        test_load_wait();
        test_chain();
        test_bypass();
        test_capacity();
        test_stall();
        $display("finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: tb/exec_cluster_properties.sv
`timescale 1ns/1ps

module exec_cluster_properties (
    input logic               clk,
    input logic               rst,
    input logic               ena,
    input logic               dispatch,
    input logic               has_capacity,
    input exec_pkg::rob_tag_t alu_cdb_tag,
    input exec_pkg::data_t    alu_cdb_data
);

    // bus idle in the first cycle out of reset
    reset_idle: assert property (@(posedge clk)
        $past(rst) |-> alu_cdb_tag == exec_pkg::no_tag)
        else $error("ALU bus carries a tag right after reset");

    no_overflow: assert property (@(posedge clk) disable iff (rst)
        dispatch |-> has_capacity)
        else $error("dispatch while the station is full");

    stall_hold: assert property (@(posedge clk) disable iff (rst)
        !ena |=> $stable(alu_cdb_tag) && $stable(alu_cdb_data))
        else $error("ALU bus changed during a stall");

endmodule

bind exec_cluster exec_cluster_properties props0 (
    .clk          (clk),
    .rst          (rst),
    .ena          (ena),
    .dispatch     (dispatch),
    .has_capacity (has_capacity),
    .alu_cdb_tag  (alu_cdb_tag),
    .alu_cdb_data (alu_cdb_data)
);

// File: rtl/exec_cluster.sv
`timescale 1ns/1ps

module exec_cluster #(
    parameter int RS_DEPTH = 15
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               ena,

    input  logic               dispatch,
    input  exec_pkg::alu_op_t  op,
    input  exec_pkg::data_t    vj,
    input  exec_pkg::data_t    vk,
    input  exec_pkg::data_t    pc,
    input  exec_pkg::data_t    imm,
    input  exec_pkg::rob_tag_t qj,
    input  exec_pkg::rob_tag_t qk,
    input  exec_pkg::rob_tag_t rd_tag,
    input  exec_pkg::rob_tag_t ls_cdb_tag,
    input  exec_pkg::data_t    ls_cdb_data,

    output logic               has_capacity,
    output exec_pkg::rob_tag_t alu_cdb_tag,
    output exec_pkg::data_t    alu_cdb_data
);

    exec_pkg::alu_op_t  issue_op;
    exec_pkg::data_t    issue_vj;
    exec_pkg::data_t    issue_vk;
    exec_pkg::data_t    issue_pc;
    exec_pkg::data_t    issue_imm;
    exec_pkg::rob_tag_t issue_tag;

    reservation_station #(
        .RS_DEPTH(RS_DEPTH)
    ) rs0 (
        .clk          (clk),
        .rst          (rst),
        .ena          (ena),
        .dispatch     (dispatch),
        .op           (op),
        .vj           (vj),
        .vk           (vk),
        .qj           (qj),
        .qk           (qk),
        .pc           (pc),
        .imm          (imm),
        .rd_tag       (rd_tag),
        // ALU result bus loops back into the station
        .alu_cdb_tag  (alu_cdb_tag),
        .alu_cdb_data (alu_cdb_data),
        .ls_cdb_tag   (ls_cdb_tag),
        .ls_cdb_data  (ls_cdb_data),
        .has_capacity (has_capacity),
        .issue_op     (issue_op),
        .issue_vj     (issue_vj),
        .issue_vk     (issue_vk),
        .issue_pc     (issue_pc),
        .issue_imm    (issue_imm),
        .issue_tag    (issue_tag)
    );

    int_alu alu0 (
        .clk       (clk),
        .rst       (rst),
        .ena       (ena),
        .issue_op  (issue_op),
        .issue_vj  (issue_vj),
        .issue_vk  (issue_vk),
        .issue_pc  (issue_pc),
        .issue_imm (issue_imm),
        .issue_tag (issue_tag),
        .cdb_tag   (alu_cdb_tag),
        .cdb_data  (alu_cdb_data)
    );

endmodule

// File: rtl/int_alu.sv
`timescale 1ns/1ps

module int_alu (
    input  logic               clk,
    input  logic               rst,
    input  logic               ena,

    input  exec_pkg::alu_op_t  issue_op,
    input  exec_pkg::data_t    issue_vj,
    input  exec_pkg::data_t    issue_vk,
    input  exec_pkg::data_t    issue_pc,
    input  exec_pkg::data_t    issue_imm,
    input  exec_pkg::rob_tag_t issue_tag,

    output exec_pkg::rob_tag_t cdb_tag,
    output exec_pkg::data_t    cdb_data
);

    exec_pkg::data_t result;
    logic [4:0]      shamt;

    assign shamt = issue_vk[4:0];

    always_comb begin
        case (issue_op)
            exec_pkg::add: begin
                result = issue_vj + issue_vk;
            end
            exec_pkg::sub: begin
                result = issue_vj - issue_vk;
            end
            exec_pkg::op_and: begin
                result = issue_vj & issue_vk;
            end
            exec_pkg::op_or: begin
                result = issue_vj | issue_vk;
            end
            exec_pkg::op_xor: begin
                result = issue_vj ^ issue_vk;
            end
            exec_pkg::sll: begin
                result = issue_vj << shamt;
            end
            exec_pkg::srl: begin
                result = issue_vj >> shamt;
            end
            exec_pkg::slt: begin
                // signed compare
                result = ($signed(issue_vj) < $signed(issue_vk)) ? 1 : 0;
            end
            exec_pkg::addi: begin
                result = issue_vj + issue_imm;
            end
            exec_pkg::auipc: begin
                result = issue_pc + issue_imm;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // result bus, one broadcast per issued op
    always_ff @(posedge clk) begin
        if (rst) begin
            cdb_tag <= exec_pkg::no_tag;
        end else if (ena) begin
            cdb_tag <= (issue_op == exec_pkg::nop) ? exec_pkg::no_tag : issue_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (ena) begin
            cdb_data <= result;
        end
    end

endmodule

// File: rtl/reservation_station.sv
`timescale 1ns/1ps

module reservation_station #(
    parameter int RS_DEPTH = 15
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               ena,

    input  logic               dispatch,
    input  exec_pkg::alu_op_t  op,
    input  exec_pkg::data_t    vj,
    input  exec_pkg::data_t    vk,
    input  exec_pkg::rob_tag_t qj,
    input  exec_pkg::rob_tag_t qk,
    input  exec_pkg::data_t    pc,
    input  exec_pkg::data_t    imm,
    input  exec_pkg::rob_tag_t rd_tag,

    input  exec_pkg::rob_tag_t alu_cdb_tag,
    input  exec_pkg::data_t    alu_cdb_data,
    input  exec_pkg::rob_tag_t ls_cdb_tag,
    input  exec_pkg::data_t    ls_cdb_data,

    output logic               has_capacity,
    output exec_pkg::alu_op_t  issue_op,
    output exec_pkg::data_t    issue_vj,
    output exec_pkg::data_t    issue_vk,
    output exec_pkg::data_t    issue_pc,
    output exec_pkg::data_t    issue_imm,
    output exec_pkg::rob_tag_t issue_tag
);

    localparam int idx_w = $clog2(RS_DEPTH);

    // entry storage
    logic [RS_DEPTH-1:0] busy;
    exec_pkg::alu_op_t   ent_op  [RS_DEPTH];
    exec_pkg::data_t     ent_vj  [RS_DEPTH];
    exec_pkg::data_t     ent_vk  [RS_DEPTH];
    exec_pkg::rob_tag_t  ent_qj  [RS_DEPTH];
    exec_pkg::rob_tag_t  ent_qk  [RS_DEPTH];
    exec_pkg::data_t     ent_pc  [RS_DEPTH];
    exec_pkg::data_t     ent_imm [RS_DEPTH];
    exec_pkg::rob_tag_t  ent_tag [RS_DEPTH];

    logic [RS_DEPTH-1:0] ready;
    logic [idx_w-1:0]    free_idx;
    logic                free_found;
    logic [idx_w-1:0]    rdy_idx;
    logic                rdy_found;
    logic                disp_we;

    // a real broadcast matching a pending producer
    function automatic logic tag_hit(exec_pkg::rob_tag_t q, exec_pkg::rob_tag_t bus_tag);
        return (q != exec_pkg::no_tag) && (q == bus_tag);
    endfunction

    function automatic exec_pkg::data_t snoop_val(exec_pkg::rob_tag_t q, exec_pkg::data_t v);
        exec_pkg::data_t res;
        res = v;
        if (tag_hit(q, ls_cdb_tag)) begin
            res = ls_cdb_data;
        end else if (tag_hit(q, alu_cdb_tag)) begin
            res = alu_cdb_data;
        end
        return res;
    endfunction

    function automatic exec_pkg::rob_tag_t snoop_tag(exec_pkg::rob_tag_t q);
        exec_pkg::rob_tag_t res;
        res = q;
        if (tag_hit(q, ls_cdb_tag) || tag_hit(q, alu_cdb_tag)) begin
            res = exec_pkg::no_tag;
        end
        return res;
    endfunction

    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            ready[i] = busy[i] && (ent_qj[i] == exec_pkg::no_tag)
                               && (ent_qk[i] == exec_pkg::no_tag);
        end
    end

    // lowest free slot, scanned downward so the lowest index wins
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                free_found = 1'b1;
                free_idx   = idx_w'(i);
            end
        end
    end

    // lowest ready slot
    always_comb begin
        rdy_found = 1'b0;
        rdy_idx   = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (ready[i]) begin
                rdy_found = 1'b1;
                rdy_idx   = idx_w'(i);
            end
        end
    end

    assign has_capacity = free_found;
    assign disp_we      = dispatch && free_found;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= '0;
            issue_op <= exec_pkg::nop;
        end else if (ena) begin
            if (disp_we) begin
                busy[free_idx] <= 1'b1;
            end
            if (rdy_found) begin
                busy[rdy_idx] <= 1'b0;
                issue_op      <= ent_op[rdy_idx];
            end else begin
                issue_op <= exec_pkg::nop;
            end
        end
    end

    // entry payload, bus capture and issue operands
    always_ff @(posedge clk) begin
        if (ena) begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (disp_we && (free_idx == idx_w'(i))) begin
                    // bypass from a bus broadcasting in the same cycle
                    ent_op[i]  <= op;
                    ent_vj[i]  <= snoop_val(qj, vj);
                    ent_vk[i]  <= snoop_val(qk, vk);
                    ent_qj[i]  <= snoop_tag(qj);
                    ent_qk[i]  <= snoop_tag(qk);
                    ent_pc[i]  <= pc;
                    ent_imm[i] <= imm;
                    ent_tag[i] <= rd_tag;
                end else if (busy[i]) begin
                    ent_vj[i] <= snoop_val(ent_qj[i], ent_vj[i]);
                    ent_vk[i] <= snoop_val(ent_qk[i], ent_vk[i]);
                    ent_qj[i] <= snoop_tag(ent_qj[i]);
                    ent_qk[i] <= snoop_tag(ent_qk[i]);
                end
            end
            issue_vj  <= ent_vj[rdy_idx];
            issue_vk  <= ent_vk[rdy_idx];
            issue_pc  <= ent_pc[rdy_idx];
            issue_imm <= ent_imm[rdy_idx];
            issue_tag <= ent_tag[rdy_idx];
        end
    end

endmodule

// File: rtl/exec_pkg.sv
package exec_pkg;

    // operand, result, pc and immediate width
    localparam int data_w = 32;

    typedef logic [data_w-1:0] data_t;

    // reorder buffer tag width
    localparam int rob_tag_w = 4;

    // tag 0 means the value is already present
    typedef logic [rob_tag_w-1:0] rob_tag_t;

    localparam rob_tag_t no_tag = '0;

    // integer ALU operations
    // shifts take the shift amount from the low 5 bits of vk
    // addi and auipc use the immediate in place of vk
    typedef enum logic [3:0] {
        nop    = 4'd0,
        add    = 4'd1,
        sub    = 4'd2,
        op_and = 4'd3,
        op_or  = 4'd4,
        op_xor = 4'd5,
        sll    = 4'd6,
        srl    = 4'd7,
        slt    = 4'd8,
        addi   = 4'd9,
        auipc  = 4'd10
    } alu_op_t;

endpackage
